// ==== common/aluPkg.sv ====
package aluPkg;

	// datapath width
	localparam int dataWidth = 8;

	// log2 of dataWidth
	localparam int shamtWidth = 3;

	// opcode field width
	localparam int opWidth = 4;

	// operands and results
	typedef logic [dataWidth-1:0] dataT;

	// shift amount, low bits of b
	typedef logic [shamtWidth-1:0] shamtT;

	// opcode
	typedef logic [opWidth-1:0] opT;

	// arithmetic
	localparam opT opAdd = 4'd0;
	localparam opT opSub = 4'd1;

	// bitwise
	localparam opT opNot = 4'd2;
	localparam opT opAnd = 4'd3;
	localparam opT opOr  = 4'd4;
	localparam opT opXor = 4'd5;

	// shifts
	localparam opT opSrl = 4'd6;
	localparam opT opSll = 4'd7;
	localparam opT opSra = 4'd8;
	localparam opT opSla = 4'd9;

	// codes 10 to 15 are not assigned

endpackage

// ==== source/arithUnit.sv ====
module arithUnit (
	input  aluPkg::dataT a,
	input  aluPkg::dataT b,
	input  logic         carryIn,
	input  aluPkg::opT   op,
	output aluPkg::dataT arithResult,
	output logic         arithCarry,
	output logic         arithOverflow
);

	localparam int msb = aluPkg::dataWidth - 1;

	// sum including the carry out bit
	logic [aluPkg::dataWidth:0] sum;

	// second operand after optional inversion
	aluPkg::dataT bEff;

	// carry actually fed into the adder
	logic cinEff;

	logic isSub;

	// sign bits used for overflow
	logic signA;
	logic signB;
	logic signR;

	assign isSub = (op == aluPkg::opSub);

	// subtract is a + ~b + 1
	always_comb begin
		if (isSub) begin
			bEff   = ~b;
			cinEff = 1'b1; // carryIn ignored
		end else begin
			bEff   = b;
			cinEff = carryIn;
		end
	end

	// one wide adder for both operations
	assign sum = {1'b0, a} + {1'b0, bEff} + {{aluPkg::dataWidth{1'b0}}, cinEff};

	assign arithResult = sum[msb:0];

	// for subtract set means no borrow
	assign arithCarry = sum[aluPkg::dataWidth];

	assign signA = a[msb];
	assign signB = bEff[msb];
	assign signR = sum[msb];

	// operand signs agree, result sign differs
	always_comb begin
		if (signA == signB) begin
			arithOverflow = (signR != signA);
		end else begin
			arithOverflow = 1'b0;
		end
	end

endmodule

// ==== source/barrelShifter.sv ====
module barrelShifter (
	input  aluPkg::dataT  data,
	input  aluPkg::shamtT amount,
	input  logic          shiftLeft,
	input  logic          fillBit,
	output aluPkg::dataT  shifted,
	output logic          lastOut
);

	localparam int stages = aluPkg::shamtWidth;
	localparam int width  = aluPkg::dataWidth;

	// value entering each stage, the last entry is the output
	aluPkg::dataT stageData [0:stages];

	// last bit pushed out so far
	logic stageOut [0:stages];

	assign stageData[0] = data;
	assign stageOut[0]  = 1'b0; // zero amount gives no carry

	for (genvar i = 0; i < stages; i++) begin : gStage

		// stage i moves by 1, 2, 4
		localparam int step = 1 << i;

		aluPkg::dataT leftStep;
		aluPkg::dataT rightStep;
		logic leftOut;
		logic rightOut;

		// fill enters at the vacated end
		assign leftStep  = {stageData[i][width-step-1:0], {step{fillBit}}};
		assign rightStep = {{step{fillBit}}, stageData[i][width-1:step]};

		// lowest bit leaving the top, highest bit leaving the bottom
		assign leftOut  = stageData[i][width-step];
		assign rightOut = stageData[i][step-1];

		always_comb begin
			if (!amount[i]) begin
				stageData[i+1] = stageData[i];
			end else if (shiftLeft) begin
				stageData[i+1] = leftStep;
			end else begin
				stageData[i+1] = rightStep;
			end
		end

		// a later stage overwrites, since its bits left last
		always_comb begin
			if (!amount[i]) begin
				stageOut[i+1] = stageOut[i];
			end else if (shiftLeft) begin
				stageOut[i+1] = leftOut;
			end else begin
				stageOut[i+1] = rightOut;
			end
		end

	end

	assign shifted = stageData[stages];
	assign lastOut = stageOut[stages];

endmodule

// ==== source/shiftLogicUnit.sv ====
module shiftLogicUnit (
	input  aluPkg::dataT a,
	input  aluPkg::dataT b,
	input  aluPkg::opT   op,
	output aluPkg::dataT slResult,
	output logic         slCarry,
	output logic         slOverflow
);

	localparam int msb = aluPkg::dataWidth - 1;

	aluPkg::shamtT amount;
	aluPkg::dataT  shifted;
	logic          lastOut;
	logic          shiftLeft;
	logic          fillBit;
	logic          isShift;
	logic          slaOverflow;

	assign amount    = b[aluPkg::shamtWidth-1:0]; // upper bits of b ignored
	assign shiftLeft = (op == aluPkg::opSll) || (op == aluPkg::opSla);
	assign fillBit   = (op == aluPkg::opSra) && a[msb];
	assign isShift   = (op == aluPkg::opSrl) || (op == aluPkg::opSll) ||
	                   (op == aluPkg::opSra) || (op == aluPkg::opSla);

	barrelShifter barrelShifter_i (
		.data      (a),
		.amount    (amount),
		.shiftLeft (shiftLeft),
		.fillBit   (fillBit),
		.shifted   (shifted),
		.lastOut   (lastOut)
	);

	// any bit crossing or landing on the sign position must match it
	always_comb begin
		slaOverflow = 1'b0;
		for (int j = 1; j < aluPkg::dataWidth; j++) begin
			if ((j <= amount) && (a[msb-j] != a[msb])) begin
				slaOverflow = 1'b1;
			end
		end
	end

	always_comb begin
		case (op)
			aluPkg::opNot: slResult = ~a;
			aluPkg::opAnd: slResult = a & b;
			aluPkg::opOr:  slResult = a | b;
			aluPkg::opXor: slResult = a ^ b;
			aluPkg::opSrl, aluPkg::opSll, aluPkg::opSra: slResult = shifted;
			aluPkg::opSla: slResult = {a[msb], shifted[msb-1:0]}; // keep sign
			default:       slResult = '0;
		endcase
	end

	assign slCarry    = isShift && lastOut;
	assign slOverflow = (op == aluPkg::opSla) && slaOverflow;

endmodule

// ==== source/resultSelect.sv ====
module resultSelect (
	input  logic         clk,
	input  logic         arstN,
	input  logic         opValid,
	input  aluPkg::opT   op,
	input  aluPkg::dataT arithResult,
	input  logic         arithCarry,
	input  logic         arithOverflow,
	input  aluPkg::dataT slResult,
	input  logic         slCarry,
	input  logic         slOverflow,
	output logic         resValid,
	output aluPkg::dataT result,
	output logic         neg,
	output logic         zero,
	output logic         carry,
	output logic         overflow,
	output logic         invalidOp
);

	localparam int msb = aluPkg::dataWidth - 1;

	// selected values before the output register
	aluPkg::dataT nextResult;
	logic         nextCarry;
	logic         nextOverflow;
	logic         nextInvalid;
	logic         nextNeg;
	logic         nextZero;

	always_comb begin
		case (op)
			aluPkg::opAdd, aluPkg::opSub: begin
				nextResult   = arithResult;
				nextCarry    = arithCarry;
				nextOverflow = arithOverflow;
				nextInvalid  = 1'b0;
			end
			aluPkg::opNot, aluPkg::opAnd, aluPkg::opOr, aluPkg::opXor,
			aluPkg::opSrl, aluPkg::opSll, aluPkg::opSra, aluPkg::opSla: begin
				nextResult   = slResult;
				nextCarry    = slCarry;
				nextOverflow = slOverflow;
				nextInvalid  = 1'b0;
			end
			default: begin // codes 10 to 15
				nextResult   = '0;
				nextCarry    = 1'b0;
				nextOverflow = 1'b0;
				nextInvalid  = 1'b1;
			end
		endcase
	end

	assign nextNeg  = nextResult[msb];
	assign nextZero = (nextResult == '0);

	// one cycle pulse per accepted op
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resValid <= 1'b0;
		end else begin
			resValid <= opValid;
		end
	end

	// outputs hold until the next valid op
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			result    <= '0;
			neg       <= 1'b0;
			zero      <= 1'b0;
			carry     <= 1'b0;
			overflow  <= 1'b0;
			invalidOp <= 1'b0;
		end else if (opValid) begin
			result    <= nextResult;
			neg       <= nextNeg;
			zero      <= nextZero;
			carry     <= nextCarry;
			overflow  <= nextOverflow;
			invalidOp <= nextInvalid;
		end
	end

endmodule

// ==== source/aluCore.sv ====
module aluCore (
	input  logic         clk,
	input  logic         arstN,
	input  logic         opValid,
	input  aluPkg::opT   op,
	input  aluPkg::dataT a,
	input  aluPkg::dataT b,
	input  logic         carryIn,
	output logic         resValid,
	output aluPkg::dataT result,
	output logic         neg,
	output logic         zero,
	output logic         carry,
	output logic         overflow,
	output logic         invalidOp
);

	// arithmetic unit outputs
	aluPkg::dataT arithResult;
	logic         arithCarry;
	logic         arithOverflow;

	// logic and shift unit outputs
	aluPkg::dataT slResult;
	logic         slCarry;
	logic         slOverflow;

	arithUnit arithUnit_i (
		.a             (a),
		.b             (b),
		.carryIn       (carryIn),
		.op            (op),
		.arithResult   (arithResult),
		.arithCarry    (arithCarry),
		.arithOverflow (arithOverflow)
	);

	shiftLogicUnit shiftLogicUnit_i (
		.a          (a),
		.b          (b),
		.op         (op),
		.slResult   (slResult),
		.slCarry    (slCarry),
		.slOverflow (slOverflow)
	);

	// only registered stage of the core
	resultSelect resultSelect_i (
		.clk           (clk),
		.arstN         (arstN),
		.opValid       (opValid),
		.op            (op),
		.arithResult   (arithResult),
		.arithCarry    (arithCarry),
		.arithOverflow (arithOverflow),
		.slResult      (slResult),
		.slCarry       (slCarry),
		.slOverflow    (slOverflow),
		.resValid      (resValid),
		.result        (result),
		.neg           (neg),
		.zero          (zero),
		.carry         (carry),
		.overflow      (overflow),
		.invalidOp     (invalidOp)
	);

endmodule

// ==== test/aluRef.svh ====
`ifndef ALUREF_SVH
`define ALUREF_SVH

// packed as {invalidOp, overflow, carry, zero, neg, result}
function automatic logic [12:0] expectedAlu(
	input aluPkg::opT   opCode,
	input aluPkg::dataT opA,
	input aluPkg::dataT opB,
	input logic         cin
);
	aluPkg::dataT      res;
	logic [8:0]        wide;
	logic              c;
	logic              v;
	logic              inv;
	int                amt;
	logic signed [7:0] sa;
	logic signed [7:0] back;

	res = '0;
	c   = 1'b0;
	v   = 1'b0;
	inv = 1'b0;
	amt = opB[2:0]; // upper bits of b do not count
	sa  = opA;

	case (opCode)
		aluPkg::opAdd: begin
			wide = opA + opB + cin;
			res  = wide[7:0];
			c    = wide[8];
			v    = (opA[7] == opB[7]) && (res[7] != opA[7]);
		end
		aluPkg::opSub: begin
			res = opA - opB;
			c   = (opA >= opB); // set when no borrow
			v   = (opA[7] != opB[7]) && (res[7] != opA[7]);
		end
		aluPkg::opNot: res = ~opA;
		aluPkg::opAnd: res = opA & opB;
		aluPkg::opOr:  res = opA | opB;
		aluPkg::opXor: res = opA ^ opB;
		aluPkg::opSrl: begin
			res = opA >> amt;
			if (amt > 0) c = opA[amt-1];
		end
		aluPkg::opSll: begin
			res = opA << amt;
			if (amt > 0) c = opA[8-amt];
		end
		aluPkg::opSra: begin
			res = sa >>> amt;
			if (amt > 0) c = opA[amt-1];
		end
		aluPkg::opSla: begin
			res  = {opA[7], opA[6:0] << amt};
			back = sa <<< amt;
			back = back >>> amt; // round trip only survives without overflow
			v    = (back != sa);
			if (amt > 0) c = opA[8-amt];
		end
		default: inv = 1'b1;
	endcase

	return {inv, v, c, (res == 8'h00), res[7], res};
endfunction

`endif

// ==== test/aluCoreTb.sv ====
module aluCoreTb;

	localparam int seedInit      = 37;
	localparam int randomOps     = 200;
	localparam int timeoutCycles = 20;

	logic         clk;
	logic         arstN;
	logic         opValid;
	aluPkg::opT   op;
	aluPkg::dataT a;
	aluPkg::dataT b;
	logic         carryIn;
	logic         resValid;
	aluPkg::dataT result;
	logic         neg;
	logic         zero;
	logic         carry;
	logic         overflow;
	logic         invalidOp;

	integer seed;
	int     negCount = 0;

	// expected outputs and the negedge count at issue, in issue order
	logic [12:0] expQ [$];
	int          issueQ [$];

	aluPkg::opT shiftOps [4] = '{aluPkg::opSrl, aluPkg::opSll, aluPkg::opSra, aluPkg::opSla};

	`include "aluRef.svh"

	aluCore aluCore_i (
		.clk       (clk),
		.arstN     (arstN),
		.opValid   (opValid),
		.op        (op),
		.a         (a),
		.b         (b),
		.carryIn   (carryIn),
		.resValid  (resValid),
		.result    (result),
		.neg       (neg),
		.zero      (zero),
		.carry     (carry),
		.overflow  (overflow),
		.invalidOp (invalidOp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abortRun();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [15:0] actual,
	                          input logic [15:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
			abortRun();
		end
	endtask

	// expected packed as {invalidOp, overflow, carry, zero, neg, result}
	task automatic checkOutputs(input logic [12:0] expected);
		checkValue("result", result, expected[7:0]);
		checkValue("neg", neg, expected[8]);
		checkValue("zero", zero, expected[9]);
		checkValue("carry", carry, expected[10]);
		checkValue("overflow", overflow, expected[11]);
		checkValue("invalidOp", invalidOp, expected[12]);
	endtask

	task automatic issueOp(input aluPkg::opT opCode, input aluPkg::dataT opA,
	                       input aluPkg::dataT opB, input logic cin);
		@(posedge clk);
		opValid <= 1'b1;
		op      <= opCode;
		a       <= opA;
		b       <= opB;
		carryIn <= cin;
		expQ.push_back(expectedAlu(opCode, opA, opB, cin));
		issueQ.push_back(negCount);
	endtask

	task automatic idleCycle();
		@(posedge clk);
		opValid <= 1'b0;
		op      <= $random(seed); // don't care while opValid is low
		a       <= $random(seed);
		b       <= $random(seed);
		carryIn <= $random(seed);
	endtask

	task automatic waitForDrain();
		int count;
		count = 0;
		while (expQ.size() > 0) begin
			@(negedge clk);
			count++;
			if (count > timeoutCycles) begin
				$display("timeout: operations still left in the queue at the end");
				abortRun();
			end
		end
	endtask

	// pops one entry per resValid pulse
	initial begin
		logic [12:0] expected;
		int          issuedAt;
		int          waitCount;
		waitCount = 0;
		expected  = '0; // output register after reset
		@(posedge clk); // skip the clock's first edge at time zero
		forever begin
			@(negedge clk);
			negCount++;
			if (resValid) begin
				if (expQ.size() == 0) begin
					$display("resValid seen with no operation outstanding");
					abortRun();
				end else begin
					expected = expQ.pop_front();
					issuedAt = issueQ.pop_front();
					checkValue("latency", negCount - issuedAt, 2); // one cycle after sampling
					checkOutputs(expected);
					waitCount = 0;
				end
			end else begin
				checkOutputs(expected); // last result holds while idle
				if (expQ.size() > 0) begin
					waitCount++;
					if (waitCount > timeoutCycles) begin
						$display("timeout waiting for resValid");
						abortRun();
					end
				end
			end
		end
	end

	initial begin
		aluPkg::opT   rop;
		aluPkg::dataT ra;
		aluPkg::dataT rb;
		logic         rc;
		seed    = seedInit;
		arstN   = 1'b0;
		opValid = 1'b0;
		op      = '0;
		a       = '0;
		b       = '0;
		carryIn = 1'b0;
		repeat (4) @(posedge clk);
		arstN <= 1'b1;

		@(negedge clk);
		checkValue("resValid", resValid, 0);
		checkOutputs('0);

		// add and subtract corners
		issueOp(aluPkg::opAdd, 8'h7F, 8'h01, 1'b0);
		issueOp(aluPkg::opSub, 8'h80, 8'h01, 1'b0);
		issueOp(aluPkg::opAdd, 8'hFF, 8'h01, 1'b1);
		issueOp(aluPkg::opSub, 8'h5A, 8'h5A, 1'b1); // carryIn ignored
		issueOp(aluPkg::opAdd, 8'h00, 8'h00, 1'b0);
		issueOp(aluPkg::opAdd, 8'h80, 8'h80, 1'b0);
		issueOp(aluPkg::opSub, 8'h00, 8'h01, 1'b0);
		idleCycle();

		for (int k = 0; k < 16; k++) begin
			ra = $random(seed);
			rb = $random(seed);
			rc = $random(seed);
			issueOp((k % 2) ? aluPkg::opSub : aluPkg::opAdd, ra, rb, rc);
		end
		idleCycle();

		// bitwise
		for (int k = 0; k < 64; k++) begin
			ra = $random(seed);
			rb = $random(seed);
			rc = $random(seed);
			issueOp(aluPkg::opNot + (k % 4), ra, rb, rc);
		end
		idleCycle();

		// every shift kind at every amount
		for (int s = 0; s < 4; s++) begin
			for (int amt = 0; amt < 8; amt++) begin
				ra      = $random(seed);
				rb      = $random(seed);
				rc      = $random(seed);
				ra[7]   = amt[0] ^ s[0];
				rb[2:0] = amt;
				issueOp(shiftOps[s], ra, rb, rc);
			end
			idleCycle();
		end
		issueOp(aluPkg::opSla, 8'h40, 8'h01, 1'b0);
		issueOp(aluPkg::opSla, 8'hC0, 8'hF9, 1'b0);
		issueOp(aluPkg::opSra, 8'h80, 8'h07, 1'b0);
		idleCycle();

		// unassigned opcodes
		for (int code = 10; code < 16; code++) begin
			ra = $random(seed);
			rb = $random(seed);
			rc = $random(seed);
			issueOp(code, ra, rb, rc);
		end
		idleCycle();

		// mixed stream with idle gaps
		for (int k = 0; k < randomOps; k++) begin
			rop = $random(seed);
			ra  = $random(seed);
			rb  = $random(seed);
			rc  = $random(seed);
			issueOp(rop, ra, rb, rc);
			if (($random(seed) & 3) == 0) begin
				idleCycle();
			end
		end
		idleCycle();

		waitForDrain();
		repeat (4) @(negedge clk); // no stray pulses after the last result
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+test
common/aluPkg.sv
source/arithUnit.sv
source/barrelShifter.sv
source/shiftLogicUnit.sv
source/resultSelect.sv
source/aluCore.sv
test/aluCoreTb.sv
